// ==== verilog/river_video_pkg.sv ====
// ---------------------------------------------------------------------
// shared constants and types for the river scene video generator:
// display timing, scene limits, palette indices, bus word decoding
// ---------------------------------------------------------------------
`default_nettype none

package river_video_pkg;

   localparam int H_ACTIVE = 1280;   // clocks, two per pixel
   localparam int H_FRONT  = 32;
   localparam int H_SYNC   = 192;
   localparam int H_BACK   = 96;
   localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

   localparam int V_ACTIVE = 480;    // lines
   localparam int V_FRONT  = 10;
   localparam int V_SYNC   = 2;
   localparam int V_BACK   = 33;
   localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

   localparam int COL_W          = 10;
   localparam int ROW_W          = 10;
   localparam int COLOR_W        = 4;
   localparam int N_SLOTS        = 4;
   localparam int SPRITE_SIZE    = 32;
   localparam int SPRITE_HALF    = 16;
   localparam int N_IMAGES       = 4;
   localparam int BOUNDARY_LINES = 480;
   localparam int STATUS_ROW     = 400;   // last river row

   typedef logic [COLOR_W-1:0] color_idx_t;

   localparam color_idx_t CLR_TRANSPARENT = 4'd0;
   localparam color_idx_t CLR_GREEN       = 4'd1;
   localparam color_idx_t CLR_BLUE        = 4'd2;
   localparam color_idx_t CLR_GRAY        = 4'd7;

   typedef struct packed {
      logic [COL_W-1:0] col;
      logic [ROW_W-1:0] row;
   } pixel_pos_t;

   typedef struct packed {
      logic [COL_W-1:0] b1;
      logic [COL_W-1:0] b2;
      logic [COL_W-1:0] b3;
      logic [COL_W-1:0] b4;
   } boundaries_t;

   typedef struct packed {
      logic [COL_W-1:0] x;
      logic [8:0]       y;         // centre row
      logic             visible;
      logic [1:0]       img;
   } sprite_cfg_t;

   typedef struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
   } rgb_t;

   // one bus word, read as a column or as a row plus visible flag
   typedef union packed {
      struct packed {
         logic [5:0]       pad;
         logic [COL_W-1:0] value;
      } coord;
      struct packed {
         logic [5:0] pad;
         logic [8:0] row;
         logic       visible;
      } yword;
   } bus_word_u;

endpackage

`default_nettype wire

// ==== verilog/video_timing.sv ====
// ---------------------------------------------------------------------
// 640x480 timing from a 50 MHz clock, one pixel per two clocks
// pixel position, pixel clock, syncs and blanking
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module video_timing
   import river_video_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   output pixel_pos_t pos,
   output logic       vga_clk,
   output logic       vga_hs,
   output logic       vga_vs,
   output logic       vga_blank_n
);

   logic [10:0] hcount;   // clocks within the line
   logic [9:0]  vcount;   // line within the frame
   logic        end_of_line;
   logic        end_of_frame;

   assign end_of_line  = (hcount == 11'(H_TOTAL - 1));
   assign end_of_frame = (vcount == 10'(V_TOTAL - 1));

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         hcount <= '0;
         vcount <= '0;
      end else if (end_of_line) begin
         hcount <= '0;
         if (end_of_frame) begin
            vcount <= '0;
         end else begin
            vcount <= vcount + 10'd1;
         end
      end else begin
         hcount <= hcount + 11'd1;
      end
   end

   assign pos     = '{col: hcount[10:1], row: vcount};
   assign vga_clk = hcount[0];   // 25 MHz, rises mid pixel

   assign vga_hs = !((hcount >= 11'(H_ACTIVE + H_FRONT)) &&
                     (hcount < 11'(H_ACTIVE + H_FRONT + H_SYNC)));
   assign vga_vs = !((vcount >= 10'(V_ACTIVE + V_FRONT)) &&
                     (vcount < 10'(V_ACTIVE + V_FRONT + V_SYNC)));
   assign vga_blank_n = (hcount < 11'(H_ACTIVE)) && (vcount < 10'(V_ACTIVE));

endmodule

`default_nettype wire

// ==== verilog/scene_regs.sv ====
// ---------------------------------------------------------------------
// write-only register bank: staged river boundaries, scroll event
// and the position, visibility and image of each sprite slot
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module scene_regs
   import river_video_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        chipselect,
   input  logic        write,
   input  logic [5:0]  address,
   input  logic [15:0] writedata,
   output boundaries_t staged,
   output logic        scroll,
   output sprite_cfg_t slot_cfg [N_SLOTS]
);

   bus_word_u        wd;
   logic             wr_en;
   logic [COL_W-1:0] x_q   [N_SLOTS];
   logic [8:0]       y_q   [N_SLOTS];
   logic [1:0]       img_q [N_SLOTS];
   logic             vis_q [N_SLOTS];

   assign wd    = writedata;
   assign wr_en = chipselect && write;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         scroll <= 1'b0;
         for (int k = 0; k < N_SLOTS; k++) begin
            vis_q[k] <= 1'b0;
         end
      end else begin
         scroll <= wr_en && (address == 6'd4);   // one clock per write
         for (int k = 0; k < N_SLOTS; k++) begin
            if (wr_en && (address == 6'(6 + 3 * k))) begin
               vis_q[k] <= wd.yword.visible;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         case (address)
            6'd0:    staged.b1 <= wd.coord.value;
            6'd1:    staged.b2 <= wd.coord.value;
            6'd2:    staged.b3 <= wd.coord.value;
            6'd3:    staged.b4 <= wd.coord.value;
            default: ;
         endcase
         for (int k = 0; k < N_SLOTS; k++) begin
            if (address == 6'(5 + 3 * k)) begin
               x_q[k] <= wd.coord.value;
            end
            if (address == 6'(6 + 3 * k)) begin
               y_q[k] <= wd.yword.row;
            end
            if (address == 6'(7 + 3 * k)) begin
               img_q[k] <= writedata[1:0];
            end
         end
      end
   end

   always_comb begin
      for (int k = 0; k < N_SLOTS; k++) begin
         slot_cfg[k] = '{x: x_q[k], y: y_q[k], visible: vis_q[k], img: img_q[k]};
      end
   end

endmodule

`default_nettype wire

// ==== verilog/boundary_lines.sv ====
// ---------------------------------------------------------------------
// circular memory of river boundaries, one set per display line
// scroll pushes the staged set in as row 0
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module boundary_lines
   import river_video_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  pixel_pos_t  pos,
   input  boundaries_t staged,
   input  logic        scroll,
   output boundaries_t line_bounds
);

   boundaries_t mem [BOUNDARY_LINES];
   logic [8:0]  head;        // entry shown in row 0
   logic [8:0]  head_prev;
   logic [9:0]  rd_sum;
   logic [8:0]  rd_addr;

   assign head_prev = (head == 9'd0) ? 9'(BOUNDARY_LINES - 1) : head - 9'd1;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         head <= '0;
      end else if (scroll) begin
         head <= head_prev;
      end
   end

   always_comb begin
      rd_sum = {1'b0, head} + pos.row;
      if (pos.row >= ROW_W'(BOUNDARY_LINES)) begin
         rd_addr = '0;   // blanking rows
      end else if (rd_sum >= 10'(BOUNDARY_LINES)) begin
         rd_addr = 9'(rd_sum - 10'(BOUNDARY_LINES));
      end else begin
         rd_addr = rd_sum[8:0];
      end
   end

   always_ff @(posedge clk) begin
      if (scroll) begin
         mem[head_prev] <= staged;
      end
      line_bounds <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// ==== verilog/sprite_slot.sv ====
// ---------------------------------------------------------------------
// one 32x32 sprite slot: hit test, image row fetch from its own
// copy of the image file, and the pixel nibble at the column offset
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module sprite_slot
   import river_video_pkg::*;
(
   input  logic        clk,
   input  pixel_pos_t  pos,
   input  sprite_cfg_t cfg,
   output logic        hit,
   output color_idx_t  color
);

   logic [SPRITE_SIZE*COLOR_W-1:0] image_rom [N_IMAGES * SPRITE_SIZE];
   logic [SPRITE_SIZE*COLOR_W-1:0] row_data;
   logic [10:0]                    col_rel;   // column inside the square
   logic [10:0]                    row_rel;
   logic                           hit_now;
   logic                           hit_q;
   logic [6:0]                     row_addr_q;   // image, then row
   logic [4:0]                     col_off_q;
   logic [4:0]                     col_off_q2;

   initial begin
      $readmemh("verilog/sprite_images.hex", image_rom);
   end

   // left of the square wraps to a large value and fails the test
   assign col_rel = {1'b0, pos.col} + 11'(SPRITE_HALF) - {1'b0, cfg.x};
   assign row_rel = {1'b0, pos.row} + 11'(SPRITE_HALF) - {2'b00, cfg.y};

   assign hit_now = cfg.visible &&
                    (col_rel < 11'(SPRITE_SIZE)) &&
                    (row_rel < 11'(SPRITE_SIZE));

   always_ff @(posedge clk) begin
      hit_q <= hit_now;
      if (hit_now) begin
         row_addr_q <= {cfg.img, row_rel[4:0]};
         col_off_q  <= col_rel[4:0];
      end
   end

   always_ff @(posedge clk) begin
      row_data   <= image_rom[row_addr_q];
      hit        <= hit_q;
      col_off_q2 <= col_off_q;
   end

   // leftmost pixel sits in the top nibble
   assign color = row_data[(SPRITE_SIZE - 1 - col_off_q2) * COLOR_W +: COLOR_W];

endmodule

`default_nettype wire

// ==== verilog/pixel_mixer.sv ====
// ---------------------------------------------------------------------
// background choice, sprite priority, palette and RGB output register
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module pixel_mixer
   import river_video_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   input  pixel_pos_t         pos,
   input  boundaries_t        line_bounds,
   input  logic [N_SLOTS-1:0] hit,
   input  color_idx_t         color [N_SLOTS],
   output rgb_t               vga_rgb
);

   pixel_pos_t pos_d1;    // lines up with line_bounds
   color_idx_t bg_idx;
   color_idx_t bg_q;      // lines up with sprite hits
   color_idx_t pix_idx;
   rgb_t       pix_rgb;

   always_ff @(posedge clk) begin
      pos_d1 <= pos;
      bg_q   <= bg_idx;
   end

   always_comb begin
      if (pos_d1.row > ROW_W'(STATUS_ROW)) begin
         bg_idx = CLR_GRAY;   // status strip
      end else if (line_bounds.b3 == '0 && line_bounds.b4 == '0) begin
         if (pos_d1.col < line_bounds.b1) begin
            bg_idx = CLR_GREEN;
         end else if (pos_d1.col < line_bounds.b2) begin
            bg_idx = CLR_BLUE;
         end else begin
            bg_idx = CLR_GREEN;
         end
      end else begin
         if (pos_d1.col < line_bounds.b1) begin
            bg_idx = CLR_GREEN;
         end else if (pos_d1.col < line_bounds.b2) begin
            bg_idx = CLR_BLUE;
         end else if (pos_d1.col < line_bounds.b3) begin
            bg_idx = CLR_GREEN;
         end else if (pos_d1.col < line_bounds.b4) begin
            bg_idx = CLR_BLUE;
         end else begin
            bg_idx = CLR_GREEN;
         end
      end
   end

   // walk from the highest slot down so slot 0 ends on top
   always_comb begin
      pix_idx = bg_q;
      for (int k = N_SLOTS - 1; k >= 0; k--) begin
         if (hit[k] && (color[k] != CLR_TRANSPARENT)) begin
            pix_idx = color[k];
         end
      end
   end

   always_comb begin
      case (pix_idx)
         4'd0:    pix_rgb = 24'hffffff;   // white
         4'd1:    pix_rgb = 24'h00ff00;   // green
         4'd2:    pix_rgb = 24'h0000ff;   // blue
         4'd3:    pix_rgb = 24'hff0000;   // red
         4'd4:    pix_rgb = 24'hffff00;   // yellow
         4'd5:    pix_rgb = 24'h00ffff;   // cyan
         4'd6:    pix_rgb = 24'hff00ff;   // magenta
         4'd7:    pix_rgb = 24'h808080;   // gray
         4'd8:    pix_rgb = 24'h000000;   // black
         4'd9:    pix_rgb = 24'hffff00;
         default: pix_rgb = 24'hffffff;
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         vga_rgb <= '0;   // black
      end else begin
         vga_rgb <= pix_rgb;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/river_video.sv ====
// ---------------------------------------------------------------------
// top level of the river scene video generator
// timing, register bank, boundary memory, sprite slots and mixer
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module river_video
   import river_video_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        chipselect,
   input  logic        write,
   input  logic [5:0]  address,
   input  logic [15:0] writedata,
   output rgb_t        vga_rgb,
   output logic        vga_clk,
   output logic        vga_hs,
   output logic        vga_vs,
   output logic        vga_blank_n
);

   pixel_pos_t         pos;
   boundaries_t        staged;
   boundaries_t        line_bounds;
   logic               scroll;
   sprite_cfg_t        slot_cfg [N_SLOTS];
   logic [N_SLOTS-1:0] slot_hit;
   color_idx_t         slot_color [N_SLOTS];

   video_timing u_timing (
      .clk         (clk),
      .reset       (reset),
      .pos         (pos),
      .vga_clk     (vga_clk),
      .vga_hs      (vga_hs),
      .vga_vs      (vga_vs),
      .vga_blank_n (vga_blank_n)
   );

   scene_regs u_regs (
      .clk        (clk),
      .reset      (reset),
      .chipselect (chipselect),
      .write      (write),
      .address    (address),
      .writedata  (writedata),
      .staged     (staged),
      .scroll     (scroll),
      .slot_cfg   (slot_cfg)
   );

   boundary_lines u_bounds (
      .clk         (clk),
      .reset       (reset),
      .pos         (pos),
      .staged      (staged),
      .scroll      (scroll),
      .line_bounds (line_bounds)
   );

   for (genvar k = 0; k < N_SLOTS; k++) begin : g_slot
      sprite_slot u_slot (
         .clk   (clk),
         .pos   (pos),
         .cfg   (slot_cfg[k]),
         .hit   (slot_hit[k]),
         .color (slot_color[k])
      );
   end

   pixel_mixer u_mixer (
      .clk         (clk),
      .reset       (reset),
      .pos         (pos),
      .line_bounds (line_bounds),
      .hit         (slot_hit),
      .color       (slot_color),
      .vga_rgb     (vga_rgb)
   );

endmodule

`default_nettype wire

// ==== test/tb_river_video.sv ====
// ---------------------------------------------------------------------
// testbench for the river scene video generator: clock, reset, bus
// writes, scene and timing reference model, directed tests, summary
// ---------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_river_video
   import river_video_pkg::*;
;

   localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
   localparam int TIMEOUT_CYCLES = 5 * FRAME_CYCLES + 100 * H_TOTAL;   // five frames of tests

   logic        clk;
   logic        reset;
   logic        chipselect;
   logic        write;
   logic [5:0]  address;
   logic [15:0] writedata;
   rgb_t        vga_rgb;
   logic        vga_clk;
   logic        vga_hs;
   logic        vga_vs;
   logic        vga_blank_n;

   int           errors = 0;
   int           cycles = 0;
   int           hcnt = 0;            // model clock count in the line
   int           vcnt = 0;            // model line
   int           pipe_h [3];
   int           pipe_v [3];
   int           settled = 0;
   int           timing_checks = 0;
   int           pixel_checks = 0;
   int           sprite_checks = 0;
   logic [127:0] images [N_IMAGES * SPRITE_SIZE];
   boundaries_t  lines [$];           // row 0 first
   sprite_cfg_t  slots [N_SLOTS];

   river_video u_dut (
      .clk         (clk),
      .reset       (reset),
      .chipselect  (chipselect),
      .write       (write),
      .address     (address),
      .writedata   (writedata),
      .vga_rgb     (vga_rgb),
      .vga_clk     (vga_clk),
      .vga_hs      (vga_hs),
      .vga_vs      (vga_vs),
      .vga_blank_n (vga_blank_n)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles with %0d errors", cycles, errors);
         $display("=== FAIL ===");
         $finish;
      end
   end

   always @(posedge clk) begin
      if (!reset) begin
         if (hcnt == H_TOTAL - 1) begin
            hcnt <= 0;
            vcnt <= (vcnt == V_TOTAL - 1) ? 0 : vcnt + 1;
         end else begin
            hcnt <= hcnt + 1;
         end
      end
   end

   task automatic mismatch(input string name, input logic [23:0] got, input logic [23:0] want);
      errors++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, want);
   endtask

   function automatic logic [23:0] palette_rgb(input logic [3:0] idx);
      case (idx)
         4'd1:    return 24'h00ff00;
         4'd2:    return 24'h0000ff;
         4'd3:    return 24'hff0000;
         4'd4:    return 24'hffff00;
         4'd5:    return 24'h00ffff;
         4'd6:    return 24'hff00ff;
         4'd7:    return 24'h808080;
         4'd8:    return 24'h000000;
         4'd9:    return 24'hffff00;
         default: return 24'hffffff;   // 0 and 10 to 15
      endcase
   endfunction

   function automatic logic [3:0] river_index(input int col, input boundaries_t b);
      if (b.b3 == '0 && b.b4 == '0) begin
         if (col < int'(b.b1)) return CLR_GREEN;
         if (col < int'(b.b2)) return CLR_BLUE;
         return CLR_GREEN;
      end
      if (col < int'(b.b1)) return CLR_GREEN;
      if (col < int'(b.b2)) return CLR_BLUE;
      if (col < int'(b.b3)) return CLR_GREEN;
      if (col < int'(b.b4)) return CLR_BLUE;
      return CLR_GREEN;
   endfunction

   // known stays low where the background line was never written
   task automatic expected_index(input int col, input int row, output logic known,
                                 output logic covered, output logic [3:0] idx);
      int         dc;
      int         dr;
      int         k;
      logic       found;
      logic [3:0] nib;
      known   = 1'b0;
      covered = 1'b0;
      found   = 1'b0;
      idx     = CLR_TRANSPARENT;
      if (row > STATUS_ROW) begin
         known = 1'b1;
         idx   = CLR_GRAY;
      end else if (row < lines.size()) begin
         known = 1'b1;
         idx   = river_index(col, lines[row]);
      end
      for (k = 0; k < N_SLOTS; k++) begin
         dc = col - (int'(slots[k].x) - SPRITE_HALF);
         dr = row - (int'(slots[k].y) - SPRITE_HALF);
         if (slots[k].visible && dc >= 0 && dc < SPRITE_SIZE && dr >= 0 && dr < SPRITE_SIZE) begin
            covered = 1'b1;
            nib = 4'(images[int'(slots[k].img) * SPRITE_SIZE + dr] >> ((SPRITE_SIZE - 1 - dc) * 4));
            if (!found && nib != CLR_TRANSPARENT) begin   // lowest slot wins
               found = 1'b1;
               known = 1'b1;
               idx   = nib;
            end
         end
      end
   endtask

   task automatic verify_timing();
      logic exp_clk;
      logic exp_hs;
      logic exp_vs;
      logic exp_blank_n;
      exp_clk     = (hcnt % 2) == 1;
      exp_hs      = !(hcnt >= H_ACTIVE + H_FRONT && hcnt < H_ACTIVE + H_FRONT + H_SYNC);
      exp_vs      = !(vcnt >= V_ACTIVE + V_FRONT && vcnt < V_ACTIVE + V_FRONT + V_SYNC);
      exp_blank_n = hcnt < H_ACTIVE && vcnt < V_ACTIVE;
      timing_checks++;
      assert (vga_clk == exp_clk) else mismatch("vga_clk", 24'(vga_clk), 24'(exp_clk));
      assert (vga_hs == exp_hs) else mismatch("vga_hs", 24'(vga_hs), 24'(exp_hs));
      assert (vga_vs == exp_vs) else mismatch("vga_vs", 24'(vga_vs), 24'(exp_vs));
      assert (vga_blank_n == exp_blank_n)
         else mismatch("vga_blank_n", 24'(vga_blank_n), 24'(exp_blank_n));
   endtask

   task automatic compare_pixel(input int h, input int v);
      logic        known;
      logic        covered;
      logic [3:0]  idx;
      logic [23:0] want;
      if (h < H_ACTIVE && v < V_ACTIVE) begin
         expected_index(h / 2, v, known, covered, idx);
         if (known) begin
            want = palette_rgb(idx);
            pixel_checks++;
            if (covered) sprite_checks++;
            assert (vga_rgb == want)
               else mismatch($sformatf("vga_rgb(%0d,%0d)", h / 2, v), vga_rgb, want);
         end
      end
   endtask

   // rgb trails the counters by three clocks
   always @(negedge clk) begin
      if (!reset) begin
         verify_timing();
         if (settled >= 3) compare_pixel(pipe_h[2], pipe_v[2]);
         pipe_h[2] = pipe_h[1];
         pipe_v[2] = pipe_v[1];
         pipe_h[1] = pipe_h[0];
         pipe_v[1] = pipe_v[0];
         pipe_h[0] = hcnt;
         pipe_v[0] = vcnt;
         if (settled < 3) settled = settled + 1;
      end
   end

   task automatic bus_write(input logic [5:0] addr, input logic [15:0] data);
      @(posedge clk);
      #1;
      chipselect = 1'b1;
      write      = 1'b1;
      address    = addr;
      writedata  = data;
      @(posedge clk);
      #1;
      chipselect = 1'b0;
      write      = 1'b0;
   endtask

   task automatic push_line(input boundaries_t b);
      bus_write(6'd0, 16'(b.b1));
      bus_write(6'd1, 16'(b.b2));
      bus_write(6'd2, 16'(b.b3));
      bus_write(6'd3, 16'(b.b4));
      bus_write(6'd4, 16'd0);
      lines.push_front(b);
      if (lines.size() > BOUNDARY_LINES) void'(lines.pop_back());
   endtask

   task automatic place_slot(input int k, input int x, input int y, input logic vis,
                             input int img);
      bus_write(6'(5 + 3 * k), 16'(x));
      bus_write(6'(6 + 3 * k), 16'(y * 2 + int'(vis)));   // centre row above visible bit
      bus_write(6'(7 + 3 * k), 16'(img));
      slots[k] = '{x: 10'(x), y: 9'(y), visible: vis, img: 2'(img)};
   endtask

   function automatic boundaries_t random_one_river();
      boundaries_t b;
      b.b1 = 10'(10 + $urandom % 300);
      b.b2 = b.b1 + 10'(1 + $urandom % 300);
      b.b3 = '0;
      b.b4 = '0;
      return b;
   endfunction

   function automatic boundaries_t random_two_rivers();
      boundaries_t b;
      b.b1 = 10'(10 + $urandom % 140);
      b.b2 = b.b1 + 10'(1 + $urandom % 150);
      b.b3 = b.b2 + 10'(1 + $urandom % 150);
      b.b4 = b.b3 + 10'(1 + $urandom % 150);
      return b;
   endfunction

   task automatic wait_vblank();
      while (vcnt != V_ACTIVE) @(negedge clk);
   endtask

   // next frame is checked by the pixel compare
   task automatic wait_frame();
      while (vcnt != 0) @(negedge clk);
      while (vcnt != V_ACTIVE) @(negedge clk);
   endtask

   task automatic reset_and_timing();
      assert (vga_rgb == 24'h000000) else mismatch("vga_rgb", vga_rgb, 24'h000000);
      wait_vblank();
   endtask

   task automatic single_river();
      wait_vblank();
      push_line(random_one_river());
      wait_frame();
   endtask

   task automatic river_order();
      wait_vblank();
      push_line(random_two_rivers());   // A
      push_line(random_two_rivers());   // B
      push_line(random_two_rivers());   // C
      wait_frame();
   endtask

   task automatic sprite_drawing();
      int x;
      int y;
      x = 16 + $urandom % 608;
      y = 16 + $urandom % 448;
      wait_vblank();
      repeat (BOUNDARY_LINES) push_line(random_two_rivers());   // every row now known
      place_slot(0, x, y, 1'b1, $urandom % N_IMAGES);
      place_slot(1, x, y, 1'b0, $urandom % N_IMAGES);
      place_slot(2, x, y, 1'b0, 0);
      place_slot(3, x, y, 1'b0, 0);
      wait_frame();
   endtask

   task automatic slot_priority();
      int x;
      int y;
      int img0;
      x = 16 + $urandom % 584;
      y = 16 + $urandom % 424;
      img0 = $urandom % N_IMAGES;
      wait_vblank();
      place_slot(0, x, y, 1'b1, img0);
      place_slot(2, x + 8, y + 8, 1'b1, (img0 + 1 + $urandom % 3) % N_IMAGES);
      wait_frame();
   endtask

   initial begin
      void'($urandom(32'h869f));
      clk        = 1'b0;
      reset      = 1'b1;
      chipselect = 1'b0;
      write      = 1'b0;
      address    = '0;
      writedata  = '0;
      $readmemh("verilog/sprite_images.hex", images);
      for (int k = 0; k < N_SLOTS; k++) begin
         slots[k] = '0;
      end
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;
      reset_and_timing();
      single_river();
      river_order();
      sprite_drawing();
      slot_priority();
      $display("timing checks %0d, pixel checks %0d, sprite pixels %0d, errors %0d",
               timing_checks, pixel_checks, sprite_checks, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/sprite_images.hex ====
// 128 rows of 128 bits, 32 rows per image, images 0 to 3 in order
// each row holds 32 palette nibbles, leftmost pixel in the top nibble
33333333333333333333333333333333
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000044444444000000000003
30000000000044444444000000000003
30000000000044444444000000000003
30000000000044444444000000000003
30000000000044444444000000000003
30000000000044444444000000000003
30000000000044444444000000000003
30000000000044444444000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
30000000000000000000000000000003
33333333333333333333333333333333
55550000555500005555000055550000
55550000555500005555000055550000
55550000555500005555000055550000
55550000555500005555000055550000
00005555000055550000555500005555
00005555000055550000555500005555
00005555000055550000555500005555
00005555000055550000555500005555
55550000555500005555000055550000
55550000555500005555000055550000
55550000555500005555000055550000
55550000555500005555000055550000
00005555000055550000555500005555
00005555000055550000555500005555
00005555000055550000555500005555
00005555000055550000555500005555
55550000555500005555000055550000
55550000555500005555000055550000
55550000555500005555000055550000
55550000555500005555000055550000
00005555000055550000555500005555
00005555000055550000555500005555
00005555000055550000555500005555
00005555000055550000555500005555
55550000555500005555000055550000
55550000555500005555000055550000
55550000555500005555000055550000
55550000555500005555000055550000
00005555000055550000555500005555
00005555000055550000555500005555
00005555000055550000555500005555
00005555000055550000555500005555
00000000000000000000000000000000
0123456789abcdef0123456789abcdef
11111111111111111111111111111111
0123456789abcdef0123456789abcdef
22222222222222222222222222222222
0123456789abcdef0123456789abcdef
33333333333333333333333333333333
0123456789abcdef0123456789abcdef
44444444444444444444444444444444
0123456789abcdef0123456789abcdef
55555555555555555555555555555555
0123456789abcdef0123456789abcdef
66666666666666666666666666666666
0123456789abcdef0123456789abcdef
77777777777777777777777777777777
0123456789abcdef0123456789abcdef
88888888888888888888888888888888
0123456789abcdef0123456789abcdef
99999999999999999999999999999999
0123456789abcdef0123456789abcdef
aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa
0123456789abcdef0123456789abcdef
bbbbbbbbbbbbbbbbbbbbbbbbbbbbbbbb
0123456789abcdef0123456789abcdef
cccccccccccccccccccccccccccccccc
0123456789abcdef0123456789abcdef
dddddddddddddddddddddddddddddddd
0123456789abcdef0123456789abcdef
eeeeeeeeeeeeeeeeeeeeeeeeeeeeeeee
0123456789abcdef0123456789abcdef
ffffffffffffffffffffffffffffffff
0123456789abcdef0123456789abcdef
fedcba9876543210fedcba9876543210
00000000aaaaaaaabbbbbbbb00000000
fedcba9876543210fedcba9876543210
00000000aaaaaaaabbbbbbbb00000000
fedcba9876543210fedcba9876543210
00000000aaaaaaaabbbbbbbb00000000
fedcba9876543210fedcba9876543210
00000000aaaaaaaabbbbbbbb00000000
fedcba9876543210fedcba9876543210
00000000aaaaaaaabbbbbbbb00000000
fedcba9876543210fedcba9876543210
00000000aaaaaaaabbbbbbbb00000000
fedcba9876543210fedcba9876543210
00000000aaaaaaaabbbbbbbb00000000
fedcba9876543210fedcba9876543210
00000000aaaaaaaabbbbbbbb00000000
fedcba9876543210fedcba9876543210
00000000aaaaaaaabbbbbbbb00000000
fedcba9876543210fedcba9876543210
00000000aaaaaaaabbbbbbbb00000000
fedcba9876543210fedcba9876543210
00000000aaaaaaaabbbbbbbb00000000
fedcba9876543210fedcba9876543210
00000000aaaaaaaabbbbbbbb00000000
fedcba9876543210fedcba9876543210
00000000aaaaaaaabbbbbbbb00000000
fedcba9876543210fedcba9876543210
00000000aaaaaaaabbbbbbbb00000000
fedcba9876543210fedcba9876543210
00000000aaaaaaaabbbbbbbb00000000
fedcba9876543210fedcba9876543210
00000000aaaaaaaabbbbbbbb00000000

// ==== river_video.f ====
verilog/river_video_pkg.sv
verilog/video_timing.sv
verilog/scene_regs.sv
verilog/boundary_lines.sv
verilog/sprite_slot.sv
verilog/pixel_mixer.sv
verilog/river_video.sv
test/tb_river_video.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the river video testbench with Verilator, run it, then scan the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_river_video \
   -f river_video.f -o sim_river_video \
   && ./obj_dir/sim_river_video > sim.log 2>&1 \
   || echo "=== FAIL ===" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0
